/* include/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data and pc width
`define CORE_XLEN 32

// architectural registers
`define CORE_NREGS 32
`define CORE_RADDR_W 5

// execute lanes
`define CORE_NLANES 2

`endif

/* rtl/uop_pkg.sv */
`include "core_config.svh"

package uop_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    // register 0 reads as zero
    typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_sll = 4'd5,
        op_srl = 4'd6,
        op_slt = 4'd7
    } alu_op_e;

    // one issued micro-op
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        // second operand from imm instead of rk
        logic      use_imm;
        word_t     imm;
        word_t     pc;
    } uop_t;

endpackage

/* rtl/result_pkg.sv */
package result_pkg;

    // micro-op with its source values, input of a lane
    typedef struct packed {
        uop_pkg::uop_t  uop;
        uop_pkg::word_t src_j;
        uop_pkg::word_t src_k;
    } ex_in_t;

    // writeback record, also used for forwarding and trace
    typedef struct packed {
        logic              valid;
        uop_pkg::word_t    pc;
        uop_pkg::reg_addr_t rd;
        uop_pkg::word_t    data;
    } wb_t;

endpackage

/* rtl/register_file.sv */
`include "core_config.svh"

module register_file (
    input  logic               aclk,
    input  result_pkg::wb_t    i_wb0,
    input  result_pkg::wb_t    i_wb1,
    input  uop_pkg::reg_addr_t i_raddr_j0,
    input  uop_pkg::reg_addr_t i_raddr_k0,
    input  uop_pkg::reg_addr_t i_raddr_j1,
    input  uop_pkg::reg_addr_t i_raddr_k1,
    output uop_pkg::word_t     o_rdata_j0,
    output uop_pkg::word_t     o_rdata_k0,
    output uop_pkg::word_t     o_rdata_j1,
    output uop_pkg::word_t     o_rdata_k1
);

    // no storage behind register 0
    uop_pkg::word_t regs [1:`CORE_NREGS-1] = '{default: '0};

    // lane 1 write lands last
    always_ff @(posedge aclk) begin
        if (i_wb0.valid && i_wb0.rd != '0) begin
            regs[i_wb0.rd] <= i_wb0.data;
        end
        if (i_wb1.valid && i_wb1.rd != '0) begin
            regs[i_wb1.rd] <= i_wb1.data;
        end
    end

    // write-through, lane 1 over lane 0
    function automatic uop_pkg::word_t read_port(uop_pkg::reg_addr_t addr);
        uop_pkg::word_t value;
        value = '0;
        if (addr != '0) begin
            value = regs[addr];
            if (i_wb0.valid && i_wb0.rd == addr) begin
                value = i_wb0.data;
            end
            if (i_wb1.valid && i_wb1.rd == addr) begin
                value = i_wb1.data;
            end
        end
        return value;
    endfunction

    always_comb begin
        o_rdata_j0 = read_port(i_raddr_j0);
        o_rdata_k0 = read_port(i_raddr_k0);
        o_rdata_j1 = read_port(i_raddr_j1);
        o_rdata_k1 = read_port(i_raddr_k1);
    end

    // register 0 reads zero on every port, even while a write targets it
    a_r0_discarded: assert property (@(posedge aclk)
        (i_raddr_j0 != '0 || o_rdata_j0 == '0) && (i_raddr_k0 != '0 || o_rdata_k0 == '0)
        && (i_raddr_j1 != '0 || o_rdata_j1 == '0) && (i_raddr_k1 != '0 || o_rdata_k1 == '0));

endmodule

/* rtl/operand_read.sv */
`include "core_config.svh"

module operand_read (
    input  logic                aclk,
    input  logic                aresetn,
    input  uop_pkg::uop_t       i_lane0,
    input  uop_pkg::uop_t       i_lane1,
    output uop_pkg::reg_addr_t  o_raddr_j0,
    output uop_pkg::reg_addr_t  o_raddr_k0,
    output uop_pkg::reg_addr_t  o_raddr_j1,
    output uop_pkg::reg_addr_t  o_raddr_k1,
    input  uop_pkg::word_t      i_rdata_j0,
    input  uop_pkg::word_t      i_rdata_k0,
    input  uop_pkg::word_t      i_rdata_j1,
    input  uop_pkg::word_t      i_rdata_k1,
    output result_pkg::ex_in_t  o_ex0,
    output result_pkg::ex_in_t  o_ex1
);

    uop_pkg::uop_t      lane_in [`CORE_NLANES];
    uop_pkg::word_t     rdata_j [`CORE_NLANES];
    uop_pkg::word_t     rdata_k [`CORE_NLANES];

    // execute-unit input registers
    uop_pkg::uop_t      euir_q [`CORE_NLANES];

    // operand registers feeding the lanes
    result_pkg::ex_in_t opnd_q [`CORE_NLANES];

    assign lane_in[0] = i_lane0;
    assign lane_in[1] = i_lane1;

    assign rdata_j[0] = i_rdata_j0;
    assign rdata_k[0] = i_rdata_k0;
    assign rdata_j[1] = i_rdata_j1;
    assign rdata_k[1] = i_rdata_k1;

    always_ff @(posedge aclk) begin
        for (int l = 0; l < `CORE_NLANES; l++) begin
            euir_q[l]       <= lane_in[l];
            opnd_q[l].uop   <= euir_q[l];
            opnd_q[l].src_j <= rdata_j[l];
            opnd_q[l].src_k <= rdata_k[l];
            if (!aresetn) begin
                euir_q[l].valid     <= 1'b0;
                opnd_q[l].uop.valid <= 1'b0;
            end
        end
    end

    // register file is read while the pair sits in the input registers
    assign o_raddr_j0 = euir_q[0].rj;
    assign o_raddr_k0 = euir_q[0].rk;
    assign o_raddr_j1 = euir_q[1].rj;
    assign o_raddr_k1 = euir_q[1].rk;

    assign o_ex0 = opnd_q[0];
    assign o_ex1 = opnd_q[1];

    // issue side: lane 1 only pairs with lane 0
    a_lane1_needs_lane0: assert property (@(posedge aclk) disable iff (!aresetn)
        i_lane1.valid |-> i_lane0.valid);

endmodule

/* rtl/alu_lane.sv */
module alu_lane (
    input  logic               aclk,
    input  logic               aresetn,
    input  result_pkg::ex_in_t i_ex,
    input  result_pkg::wb_t    i_fwd0,
    input  result_pkg::wb_t    i_fwd1,
    output result_pkg::wb_t    o_wb
);

    uop_pkg::word_t src_a;
    uop_pkg::word_t src_k_fwd;
    uop_pkg::word_t src_b;
    uop_pkg::word_t result;
    logic [4:0]     shamt;

    // late forwarding from the previous pair, lane 1 is younger
    function automatic uop_pkg::word_t forward(uop_pkg::reg_addr_t addr,
                                               uop_pkg::word_t value);
        uop_pkg::word_t v;
        v = value;
        if (addr != '0) begin
            if (i_fwd0.valid && i_fwd0.rd == addr) begin
                v = i_fwd0.data;
            end
            if (i_fwd1.valid && i_fwd1.rd == addr) begin
                v = i_fwd1.data;
            end
        end
        return v;
    endfunction

    always_comb begin
        src_a     = forward(i_ex.uop.rj, i_ex.src_j);
        src_k_fwd = forward(i_ex.uop.rk, i_ex.src_k);
        src_b     = i_ex.uop.use_imm ? i_ex.uop.imm : src_k_fwd;
        shamt     = src_b[4:0];
    end

    always_comb begin
        case (i_ex.uop.op)
            uop_pkg::op_add: result = src_a + src_b;
            uop_pkg::op_sub: result = src_a - src_b;
            uop_pkg::op_and: result = src_a & src_b;
            uop_pkg::op_or:  result = src_a | src_b;
            uop_pkg::op_xor: result = src_a ^ src_b;
            uop_pkg::op_sll: result = src_a << shamt;
            uop_pkg::op_srl: result = src_a >> shamt;
            uop_pkg::op_slt: result = uop_pkg::word_t'($signed(src_a) < $signed(src_b));
            default:         result = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        o_wb.pc   <= i_ex.uop.pc;
        o_wb.rd   <= i_ex.uop.rd;
        o_wb.data <= result;
        if (!aresetn) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= i_ex.uop.valid;
        end
    end

    // operand stage must hand over a known op
    a_op_defined: assert property (@(posedge aclk) disable iff (!aresetn)
        i_ex.uop.valid |-> (i_ex.uop.op inside {uop_pkg::op_add, uop_pkg::op_sub,
                                                 uop_pkg::op_and, uop_pkg::op_or,
                                                 uop_pkg::op_xor, uop_pkg::op_sll,
                                                 uop_pkg::op_srl, uop_pkg::op_slt}));

endmodule

/* rtl/core_top.sv */
`include "core_config.svh"

module core_top (
    input  logic            aclk,
    input  logic            aresetn,
    input  uop_pkg::uop_t   i_lane0,
    input  uop_pkg::uop_t   i_lane1,
    output result_pkg::wb_t o_wb0,
    output result_pkg::wb_t o_wb1
);

    uop_pkg::reg_addr_t raddr_j0;
    uop_pkg::reg_addr_t raddr_k0;
    uop_pkg::reg_addr_t raddr_j1;
    uop_pkg::reg_addr_t raddr_k1;
    uop_pkg::word_t     rdata_j0;
    uop_pkg::word_t     rdata_k0;
    uop_pkg::word_t     rdata_j1;
    uop_pkg::word_t     rdata_k1;

    result_pkg::ex_in_t ex [`CORE_NLANES];
    result_pkg::wb_t    wb [`CORE_NLANES];

    operand_read operand_read_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_lane0    (i_lane0),
        .i_lane1    (i_lane1),
        .o_raddr_j0 (raddr_j0),
        .o_raddr_k0 (raddr_k0),
        .o_raddr_j1 (raddr_j1),
        .o_raddr_k1 (raddr_k1),
        .i_rdata_j0 (rdata_j0),
        .i_rdata_k0 (rdata_k0),
        .i_rdata_j1 (rdata_j1),
        .i_rdata_k1 (rdata_k1),
        .o_ex0      (ex[0]),
        .o_ex1      (ex[1])
    );

    register_file register_file_i (
        .aclk       (aclk),
        .i_wb0      (wb[0]),
        .i_wb1      (wb[1]),
        .i_raddr_j0 (raddr_j0),
        .i_raddr_k0 (raddr_k0),
        .i_raddr_j1 (raddr_j1),
        .i_raddr_k1 (raddr_k1),
        .o_rdata_j0 (rdata_j0),
        .o_rdata_k0 (rdata_k0),
        .o_rdata_j1 (rdata_j1),
        .o_rdata_k1 (rdata_k1)
    );

    // every lane sees both writeback records for forwarding
    for (genvar l = 0; l < `CORE_NLANES; l++) begin : g_lane
        alu_lane alu_lane_i (
            .aclk    (aclk),
            .aresetn (aresetn),
            .i_ex    (ex[l]),
            .i_fwd0  (wb[0]),
            .i_fwd1  (wb[1]),
            .o_wb    (wb[l])
        );
    end

    // debug trace
    assign o_wb0 = wb[0];
    assign o_wb1 = wb[1];

endmodule

/* verification/core_tb.sv */
`include "core_config.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 8;
    localparam int directed_cycles = 80;
    localparam int random_pairs    = 500;
    localparam int drain_cycles    = 4;
    localparam int test_cycles     = reset_cycles + directed_cycles + random_pairs + drain_cycles;

    localparam uop_pkg::uop_t   no_uop  = '0;
    localparam result_pkg::wb_t idle_wb = '0;

    logic            aclk;
    logic            aresetn;
    uop_pkg::uop_t   i_lane0;
    uop_pkg::uop_t   i_lane1;
    result_pkg::wb_t o_wb0;
    result_pkg::wb_t o_wb1;

    uop_pkg::word_t  model_regs [`CORE_NREGS];
    result_pkg::wb_t exp0_q [$];
    result_pkg::wb_t exp1_q [$];
    logic [31:0]     lcg_state = 32'h2ebc70e0;
    uop_pkg::word_t  next_pc = 32'h0000_1000;
    int              issued_count = 0;
    int              checked_count = 0;

    core_top core_top_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_lane0 (i_lane0),
        .i_lane1 (i_lane1),
        .o_wb0   (o_wb0),
        .o_wb1   (o_wb1)
    );

    initial begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected result from the op rules and the model registers
    function automatic uop_pkg::word_t ref_result(uop_pkg::uop_t u);
        uop_pkg::word_t a;
        uop_pkg::word_t b;
        uop_pkg::word_t res;
        a = model_regs[u.rj];
        b = u.use_imm ? u.imm : model_regs[u.rk];
        case (u.op)
            uop_pkg::op_add: res = a + b;
            uop_pkg::op_sub: res = a - b;
            uop_pkg::op_and: res = a & b;
            uop_pkg::op_or:  res = a | b;
            uop_pkg::op_xor: res = a ^ b;
            uop_pkg::op_sll: res = a << b[4:0];
            uop_pkg::op_srl: res = a >> b[4:0];
            uop_pkg::op_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:         res = '0;
        endcase
        return res;
    endfunction

    function automatic uop_pkg::uop_t make_reg_uop(uop_pkg::alu_op_e op, uop_pkg::reg_addr_t rd,
                                                   uop_pkg::reg_addr_t rj, uop_pkg::reg_addr_t rk);
        uop_pkg::uop_t u;
        u = '0;
        u.valid = 1'b1;
        u.op = op;
        u.rd = rd;
        u.rj = rj;
        u.rk = rk;
        return u;
    endfunction

    function automatic uop_pkg::uop_t make_imm_uop(uop_pkg::alu_op_e op, uop_pkg::reg_addr_t rd,
                                                   uop_pkg::reg_addr_t rj, uop_pkg::word_t imm);
        uop_pkg::uop_t u;
        u = make_reg_uop(op, rd, rj, 5'd0);
        u.use_imm = 1'b1;
        u.imm = imm;
        return u;
    endfunction

    // small register range keeps hazards frequent
    function automatic uop_pkg::uop_t random_uop();
        logic [31:0]   r1;
        logic [31:0]   r2;
        uop_pkg::uop_t u;
        r1 = lcg_next();
        r2 = lcg_next();
        u = '0;
        u.valid = 1'b1;
        u.op = uop_pkg::alu_op_e'({1'b0, r1[31:29]});
        u.rd = {2'b00, r1[28:26]};
        u.rj = {2'b00, r1[25:23]};
        u.rk = {2'b00, r1[22:20]};
        u.use_imm = r1[19];
        u.imm = r2[30] ? r2 : {27'd0, r2[31:27]};
        return u;
    endfunction

    task automatic issue_pair(input uop_pkg::uop_t u0, input uop_pkg::uop_t u1);
        uop_pkg::uop_t a;
        uop_pkg::uop_t b;
        a = u0;
        b = u1;
        if (a.valid) begin
            a.pc = next_pc;
            next_pc += 4;
            issued_count++;
        end
        if (b.valid) begin
            b.pc = next_pc;
            next_pc += 4;
            issued_count++;
        end
        @(posedge aclk);
        #1;
        i_lane0 = a;
        i_lane1 = b;
    endtask

    task automatic idle();
        issue_pair(no_uop, no_uop);
    endtask

    // both lanes read the old registers, lane 1 writes last
    task automatic model_step(input uop_pkg::uop_t u0, input uop_pkg::uop_t u1);
        result_pkg::wb_t e0;
        result_pkg::wb_t e1;
        e0 = '0;
        e1 = '0;
        if (u0.valid) begin
            e0 = '{valid: 1'b1, pc: u0.pc, rd: u0.rd, data: ref_result(u0)};
        end
        if (u1.valid) begin
            e1 = '{valid: 1'b1, pc: u1.pc, rd: u1.rd, data: ref_result(u1)};
        end
        if (e0.valid && e0.rd != 5'd0) begin
            model_regs[e0.rd] = e0.data;
        end
        if (e1.valid && e1.rd != 5'd0) begin
            model_regs[e1.rd] = e1.data;
        end
        exp0_q.push_back(e0);
        exp1_q.push_back(e1);
    endtask

    task automatic check_wb(input result_pkg::wb_t actual, input result_pkg::wb_t expected,
                            input string lane);
        logic bad;
        bad = (actual.valid !== expected.valid);
        if (expected.valid && !bad) begin
            bad = (actual.pc !== expected.pc) || (actual.rd !== expected.rd)
                || (actual.data !== expected.data);
        end
        if (bad) begin
            $display("FAIL at %0t: %s got valid=%0b pc=%h rd=%0d data=%h", $time, lane,
                     actual.valid, actual.pc, actual.rd, actual.data);
            $display("FAIL at %0t: %s expected valid=%0b pc=%h rd=%0d data=%h", $time, lane,
                     expected.valid, expected.pc, expected.rd, expected.data);
            $display("tests failed");
            $fatal(1, "writeback mismatch");
        end else if (expected.valid) begin
            checked_count++;
        end
    endtask

    always @(posedge aclk) begin
        if (aresetn) begin
            model_step(i_lane0, i_lane1);
        end
    end

    // a pair sampled at one edge shows on o_wb after the second edge that follows
    always @(negedge aclk) begin
        if (aresetn) begin
            if (exp0_q.size() >= 3) begin
                check_wb(o_wb0, exp0_q.pop_front(), "lane 0");
                check_wb(o_wb1, exp1_q.pop_front(), "lane 1");
            end else begin
                check_wb(o_wb0, idle_wb, "lane 0");
                check_wb(o_wb1, idle_wb, "lane 1");
            end
        end
    end

    initial begin
        #((test_cycles + 20) * clk_period);
        $display("simulation hung, the watchdog ran out before the tests completed");
        $display("tests failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        uop_pkg::uop_t u0;
        uop_pkg::uop_t u1;
        logic [31:0]   r;
        for (int i = 0; i < `CORE_NREGS; i++) begin
            model_regs[i] = '0;
        end
        i_lane0 = '0;
        i_lane1 = '0;
        aresetn = 1'b0;
        repeat (reset_cycles) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        // every register reads zero after reset
        for (int p = 0; p < 8; p++) begin
            u0 = make_reg_uop(uop_pkg::op_add, 5'd0, uop_pkg::reg_addr_t'(4 * p),
                              uop_pkg::reg_addr_t'(4 * p + 1));
            u1 = make_reg_uop(uop_pkg::op_or, 5'd0, uop_pkg::reg_addr_t'(4 * p + 2),
                              uop_pkg::reg_addr_t'(4 * p + 3));
            issue_pair(u0, u1);
        end

        // every op, register and immediate forms
        issue_pair(make_imm_uop(uop_pkg::op_add, 5'd1, 5'd0, 32'h8000_0005),
                   make_imm_uop(uop_pkg::op_add, 5'd2, 5'd0, 32'd7));
        issue_pair(make_imm_uop(uop_pkg::op_add, 5'd3, 5'd0, 32'hffff_fff0),
                   make_imm_uop(uop_pkg::op_add, 5'd4, 5'd0, 32'h1234_5678));
        for (int o = 0; o < 8; o++) begin
            issue_pair(make_reg_uop(uop_pkg::alu_op_e'(o), 5'd5, 5'd1, 5'd2),
                       make_imm_uop(uop_pkg::alu_op_e'(o), 5'd6, 5'd4, 32'd35));
            issue_pair(make_reg_uop(uop_pkg::alu_op_e'(o), 5'd7, 5'd3, 5'd1),
                       make_imm_uop(uop_pkg::alu_op_e'(o), 5'd8, 5'd3, 32'hffff_fff8));
        end

        // dependent chains at distance one
        issue_pair(make_imm_uop(uop_pkg::op_add, 5'd9, 5'd0, 32'd1), no_uop);
        repeat (3) issue_pair(make_reg_uop(uop_pkg::op_add, 5'd9, 5'd9, 5'd9), no_uop);
        issue_pair(make_imm_uop(uop_pkg::op_sll, 5'd9, 5'd9, 32'd2), no_uop);
        issue_pair(make_imm_uop(uop_pkg::op_add, 5'd10, 5'd9, 32'd3),
                   make_imm_uop(uop_pkg::op_xor, 5'd11, 5'd9, 32'h0f0f_0f0f));
        issue_pair(make_reg_uop(uop_pkg::op_add, 5'd12, 5'd10, 5'd11),
                   make_imm_uop(uop_pkg::op_sll, 5'd13, 5'd11, 32'd4));
        issue_pair(make_reg_uop(uop_pkg::op_sub, 5'd14, 5'd12, 5'd13),
                   make_reg_uop(uop_pkg::op_slt, 5'd15, 5'd13, 5'd12));

        // distance two through write-through, then from the register file
        issue_pair(make_imm_uop(uop_pkg::op_add, 5'd16, 5'd0, 32'd100), no_uop);
        idle();
        issue_pair(make_imm_uop(uop_pkg::op_sub, 5'd16, 5'd16, 32'd1), no_uop);
        idle();
        issue_pair(make_reg_uop(uop_pkg::op_or, 5'd17, 5'd16, 5'd16), no_uop);
        idle();
        idle();
        issue_pair(make_reg_uop(uop_pkg::op_add, 5'd17, 5'd17, 5'd16), no_uop);

        // pair rule: old value inside a pair, lane 1 wins a shared rd
        issue_pair(make_imm_uop(uop_pkg::op_add, 5'd18, 5'd0, 32'd55),
                   make_imm_uop(uop_pkg::op_add, 5'd19, 5'd18, 32'd1));
        issue_pair(make_imm_uop(uop_pkg::op_add, 5'd20, 5'd0, 32'd1),
                   make_imm_uop(uop_pkg::op_add, 5'd20, 5'd0, 32'd2));
        issue_pair(make_reg_uop(uop_pkg::op_add, 5'd21, 5'd20, 5'd0), no_uop);
        issue_pair(make_reg_uop(uop_pkg::op_add, 5'd22, 5'd20, 5'd0), no_uop);
        issue_pair(make_reg_uop(uop_pkg::op_add, 5'd23, 5'd20, 5'd20), no_uop);

        // writes to register 0 are traced but not kept
        issue_pair(make_imm_uop(uop_pkg::op_add, 5'd0, 5'd4, 32'd1), no_uop);
        issue_pair(make_reg_uop(uop_pkg::op_add, 5'd24, 5'd0, 5'd0), no_uop);
        issue_pair(make_reg_uop(uop_pkg::op_or, 5'd25, 5'd0, 5'd4), no_uop);
        issue_pair(make_reg_uop(uop_pkg::op_xor, 5'd26, 5'd0, 5'd0), no_uop);

        // random mix of idle, single and dual issue
        repeat (random_pairs) begin
            r = lcg_next();
            if (r[31:29] == 3'd0) begin
                idle();
            end else begin
                u0 = random_uop();
                u1 = random_uop();
                u1.valid = r[28];
                issue_pair(u0, u1);
            end
        end

        repeat (drain_cycles) idle();
        @(negedge aclk);
        #1;
        if (checked_count == issued_count) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("only %0d of %0d issued instructions were seen on writeback",
                     checked_count, issued_count);
            $display("tests failed");
            $fatal(1, "missing writebacks");
        end
    end

endmodule

/* project.f */
+incdir+include
rtl/uop_pkg.sv
rtl/result_pkg.sv
rtl/register_file.sv
rtl/operand_read.sv
rtl/alu_lane.sv
rtl/core_top.sv
verification/core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f project.f --top-module core_tb -Mdir obj_dir \
    && ./obj_dir/Vcore_tb \
    || exit 1
